// File: udp_echo_pkg.sv
////////////////////
// UDP echo shared definitions
// Field widths, the echoed port number, payload FIFO depth
// and the steering FSM states
////////////////////

`default_nettype none

package udp_echo_pkg;

    // IPv4 and UDP header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // 64-bit payload beat and its byte enables
    typedef logic [63:0] axis_data_t;
    typedef logic [7:0]  axis_keep_t;

    // Front panel LEDs
    typedef logic [7:0]  led_t;

    // Datagrams to this port are sent back
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Payload beats buffered between steering and transmit
    localparam int FIFO_DEPTH = 64;

    // Steering FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASS,
        ST_DROP
    } steer_state_e;

endpackage

`default_nettype wire

// File: udp_hdr_if.sv
////////////////////
// UDP header channel
// One header per valid/ready transfer
////////////////////

`timescale 1ns/10ps
`default_nettype none

interface udp_hdr_if import udp_echo_pkg::*; ();

    logic      valid;
    logic      ready;
    // Peer address, source on receive and destination on reply
    ip_addr_t  ip_addr;
    udp_port_t source_port;
    udp_port_t dest_port;
    udp_len_t  length;

    modport src (
        output valid, ip_addr, source_port, dest_port, length,
        input  ready
    );

    modport dst (
        input  valid, ip_addr, source_port, dest_port, length,
        output ready
    );

endinterface

`default_nettype wire

// File: udp_stream_if.sv
////////////////////
// Payload stream channel
// 64-bit AXI-Stream beats with keep, last and user
////////////////////

`timescale 1ns/10ps
`default_nettype none

interface udp_stream_if import udp_echo_pkg::*; ();

    axis_data_t tdata;
    axis_keep_t tkeep;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    // Marks a bad datagram
    logic       tuser;

    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport dst (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

`default_nettype wire

// File: udp_echo_steer.sv
////////////////////
// UDP echo steering
// Accepts received headers, picks echo or drop by destination port,
// builds the reply header and routes the payload to the FIFO
// or discards it
////////////////////

`timescale 1ns/10ps
`default_nettype none

module udp_echo_steer import udp_echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  ip_addr_t   rx_ip_source_ip,
    input  udp_port_t  rx_source_port,
    input  udp_port_t  rx_dest_port,
    input  udp_len_t   rx_length,

    input  axis_data_t rx_payload_tdata,
    input  axis_keep_t rx_payload_tkeep,
    input  logic       rx_payload_tvalid,
    output logic       rx_payload_tready,
    input  logic       rx_payload_tlast,
    input  logic       rx_payload_tuser,

    udp_hdr_if.src     hdr,
    udp_stream_if.src  pay
);

    steer_state_e state;
    logic         hdr_en;
    logic         match;
    logic         in_idle;
    logic         rx_hdr_fire;
    logic         rx_last_fire;

    assign match   = (rx_dest_port == ECHO_PORT);
    assign in_idle = (state == ST_IDLE);

    // Matching headers wait for the reply slot, others are taken at once
    assign rx_hdr_ready = hdr_en && in_idle && (match ? hdr.ready : 1'b1);

    // Reply header goes out on the same edge the request is accepted
    assign hdr.valid       = hdr_en && in_idle && rx_hdr_valid && match;
    assign hdr.ip_addr     = rx_ip_source_ip;
    assign hdr.source_port = rx_dest_port;
    assign hdr.dest_port   = rx_source_port;
    assign hdr.length      = rx_length;

    // Payload forwarded in ST_PASS, swallowed in ST_DROP, held in ST_IDLE
    assign pay.tdata  = rx_payload_tdata;
    assign pay.tkeep  = rx_payload_tkeep;
    assign pay.tlast  = rx_payload_tlast;
    assign pay.tuser  = rx_payload_tuser;
    assign pay.tvalid = rx_payload_tvalid && (state == ST_PASS);

    assign rx_payload_tready = ((state == ST_PASS) && pay.tready) || (state == ST_DROP);

    assign rx_hdr_fire  = rx_hdr_valid && rx_hdr_ready;
    assign rx_last_fire = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            hdr_en <= 1'b0;
        end else begin
            // Header input opens one cycle after reset
            hdr_en <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (rx_hdr_fire) begin
                        state <= match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (rx_last_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Beat offered to the FIFO is held until taken
    assert property (@(posedge clk) disable iff (rst)
        (pay.tvalid && !pay.tready) |=>
            (pay.tvalid && $stable(pay.tdata) && $stable(pay.tlast)));

    // A waiting header keeps its ports, so the echo decision holds
    assert property (@(posedge clk) disable iff (rst)
        (rx_hdr_valid && !rx_hdr_ready) |=>
            (rx_hdr_valid && $stable(rx_dest_port) && $stable(rx_source_port)));

endmodule

`default_nettype wire

// File: axis_payload_fifo.sv
////////////////////
// Payload FIFO
// Synchronous circular buffer of AXI-Stream beats
// with data, keep, last and user
////////////////////

`timescale 1ns/10ps
`default_nettype none

module axis_payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    udp_stream_if.dst wr,
    udp_stream_if.src rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage
    axis_data_t data_mem [DEPTH];
    axis_keep_t keep_mem [DEPTH];
    logic       last_mem [DEPTH];
    logic       user_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr.tready = (count != CNT_W'(DEPTH));
    assign rd.tvalid = (count != '0);

    // Read side comes straight from the array
    assign rd.tdata = data_mem[rd_ptr];
    assign rd.tkeep = keep_mem[rd_ptr];
    assign rd.tlast = last_mem[rd_ptr];
    assign rd.tuser = user_mem[rd_ptr];

    assign wr_fire = wr.tvalid && wr.tready;
    assign rd_fire = rd.tvalid && rd.tready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            data_mem[wr_ptr] <= wr.tdata;
            keep_mem[wr_ptr] <= wr.tkeep;
            last_mem[wr_ptr] <= wr.tlast;
            user_mem[wr_ptr] <= wr.tuser;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count unchanged
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

    // Full without a read stays full, so no beat slipped in
    assert property (@(posedge clk) disable iff (rst)
        (count == CNT_W'(DEPTH) && !rd_fire) |=> (count == CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// File: udp_echo_tx.sv
////////////////////
// UDP echo transmit stage
// Buffers one reply header, passes the payload to the tx port
// and shows the first payload byte on the LEDs
////////////////////

`timescale 1ns/10ps
`default_nettype none

module udp_echo_tx import udp_echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    udp_hdr_if.dst     hdr,
    udp_stream_if.dst  pay,

    output logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,
    output ip_addr_t   tx_ip_dest_ip,
    output udp_port_t  tx_source_port,
    output udp_port_t  tx_dest_port,
    output udp_len_t   tx_length,

    output axis_data_t tx_payload_tdata,
    output axis_keep_t tx_payload_tkeep,
    output logic       tx_payload_tvalid,
    input  logic       tx_payload_tready,
    output logic       tx_payload_tlast,
    output logic       tx_payload_tuser,

    output led_t       led
);

    logic hdr_full;
    logic first_beat;

    // Slot takes a new header only when empty
    assign hdr.ready    = !hdr_full;
    assign tx_hdr_valid = hdr_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
        end else if (hdr.valid && hdr.ready) begin
            hdr_full <= 1'b1;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr.valid && hdr.ready) begin
            tx_ip_dest_ip  <= hdr.ip_addr;
            tx_source_port <= hdr.source_port;
            tx_dest_port   <= hdr.dest_port;
            tx_length      <= hdr.length;
        end
    end

    // Payload straight through from the FIFO
    assign tx_payload_tdata  = pay.tdata;
    assign tx_payload_tkeep  = pay.tkeep;
    assign tx_payload_tvalid = pay.tvalid;
    assign tx_payload_tlast  = pay.tlast;
    assign tx_payload_tuser  = pay.tuser;
    assign pay.tready        = tx_payload_tready;

    // Low byte of each datagram's first beat goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (pay.tvalid && pay.tready) begin
            if (first_beat) begin
                led <= pay.tdata[7:0];
            end
            first_beat <= pay.tlast;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=>
            (tx_hdr_valid && $stable(tx_ip_dest_ip) && $stable(tx_source_port) &&
             $stable(tx_dest_port) && $stable(tx_length)));

endmodule

`default_nettype wire

// File: udp_echo_top.sv
////////////////////
// UDP echo core
// Sends datagrams for the echo port back to their sender
// and discards all others
////////////////////

`timescale 1ns/10ps
`default_nettype none

module udp_echo_top import udp_echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Received UDP header and payload
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  ip_addr_t   rx_ip_source_ip,
    input  udp_port_t  rx_source_port,
    input  udp_port_t  rx_dest_port,
    input  udp_len_t   rx_length,
    input  axis_data_t rx_payload_tdata,
    input  axis_keep_t rx_payload_tkeep,
    input  logic       rx_payload_tvalid,
    output logic       rx_payload_tready,
    input  logic       rx_payload_tlast,
    input  logic       rx_payload_tuser,

    // Reply UDP header and payload
    output logic       tx_hdr_valid,
    input  logic       tx_hdr_ready,
    output ip_addr_t   tx_ip_dest_ip,
    output udp_port_t  tx_source_port,
    output udp_port_t  tx_dest_port,
    output udp_len_t   tx_length,
    output axis_data_t tx_payload_tdata,
    output axis_keep_t tx_payload_tkeep,
    output logic       tx_payload_tvalid,
    input  logic       tx_payload_tready,
    output logic       tx_payload_tlast,
    output logic       tx_payload_tuser,

    output led_t       led
);

    udp_hdr_if    reply_hdr ();
    udp_stream_if steer_to_fifo ();
    udp_stream_if fifo_to_tx ();

    udp_echo_steer u_steer (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_ip_source_ip  (rx_ip_source_ip),
        .rx_source_port   (rx_source_port),
        .rx_dest_port     (rx_dest_port),
        .rx_length        (rx_length),
        .rx_payload_tdata (rx_payload_tdata),
        .rx_payload_tkeep (rx_payload_tkeep),
        .rx_payload_tvalid(rx_payload_tvalid),
        .rx_payload_tready(rx_payload_tready),
        .rx_payload_tlast (rx_payload_tlast),
        .rx_payload_tuser (rx_payload_tuser),
        .hdr              (reply_hdr.src),
        .pay              (steer_to_fifo.src)
    );

    axis_payload_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .wr (steer_to_fifo.dst),
        .rd (fifo_to_tx.src)
    );

    udp_echo_tx u_tx (
        .clk              (clk),
        .rst              (rst),
        .hdr              (reply_hdr.dst),
        .pay              (fifo_to_tx.dst),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_ip_dest_ip    (tx_ip_dest_ip),
        .tx_source_port   (tx_source_port),
        .tx_dest_port     (tx_dest_port),
        .tx_length        (tx_length),
        .tx_payload_tdata (tx_payload_tdata),
        .tx_payload_tkeep (tx_payload_tkeep),
        .tx_payload_tvalid(tx_payload_tvalid),
        .tx_payload_tready(tx_payload_tready),
        .tx_payload_tlast (tx_payload_tlast),
        .tx_payload_tuser (tx_payload_tuser),
        .led              (led)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
////////////////////
// Testbench clock and reset
// Free-running clock, reset held for a fixed number of cycles
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on an edge so the DUT sees a whole number of reset cycles
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_udp_echo.sv
////////////////////
// UDP echo testbench
// Drives a table of datagrams into the core and checks reply
// headers, payload beats and LEDs against a reference model
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_udp_echo import udp_echo_pkg::*; ();

    localparam int NUM_ROWS = 8;
    localparam int TIMEOUT  = 2000;

    typedef struct packed {
        ip_addr_t   ip;
        udp_port_t  sport;
        udp_port_t  dport;
        udp_len_t   len;
        logic [7:0] beats;
        logic       user;
    } row_t;

    typedef struct packed {
        axis_data_t data;
        axis_keep_t keep;
        logic       last;
        logic       user;
    } beat_t;

    // Source IP, source port, dest port, length, beat count, tuser on last beat
    row_t rows [NUM_ROWS] = '{
        '{32'h0A00_0001, 16'd5000,  ECHO_PORT, 16'd13, 8'd1, 1'b0},
        '{32'hC0A8_0105, 16'd40000, ECHO_PORT, 16'd32, 8'd3, 1'b0},
        '{32'h0A00_0002, 16'd6000,  16'd80,    16'd20, 8'd2, 1'b0},
        '{32'hAC10_0007, 16'd1234,  ECHO_PORT, 16'd38, 8'd4, 1'b1},
        '{32'h0A00_0003, 16'd7000,  16'd1235,  16'd16, 8'd1, 1'b0},
        '{32'hC0A8_01FE, 16'd53,    ECHO_PORT, 16'd45, 8'd5, 1'b0},
        '{32'h0A00_0004, 16'd9,     16'd9999,  16'd40, 8'd4, 1'b1},
        '{32'h0A00_0005, 16'd1111,  ECHO_PORT, 16'd16, 8'd1, 1'b0}
    };

    logic       clk, rst;
    logic       rx_hdr_valid, rx_hdr_ready;
    ip_addr_t   rx_ip_source_ip;
    udp_port_t  rx_source_port, rx_dest_port;
    udp_len_t   rx_length;
    axis_data_t rx_payload_tdata;
    axis_keep_t rx_payload_tkeep;
    logic       rx_payload_tvalid, rx_payload_tready, rx_payload_tlast, rx_payload_tuser;
    logic       tx_hdr_valid, tx_hdr_ready;
    ip_addr_t   tx_ip_dest_ip;
    udp_port_t  tx_source_port, tx_dest_port;
    udp_len_t   tx_length;
    axis_data_t tx_payload_tdata;
    axis_keep_t tx_payload_tkeep;
    logic       tx_payload_tvalid, tx_payload_tready, tx_payload_tlast, tx_payload_tuser;
    led_t       led;

    // Reference model state
    row_t        hdr_q [$];
    beat_t       beat_q [$];
    row_t        hdr_exp;
    beat_t       beat_exp;
    led_t        led_exp;
    bit          tx_first;
    logic [31:0] pay_seed = 32'd50;
    logic [31:0] rdy_seed = 32'd50;
    bit          random_ready;
    bit          hold_off;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk_gen (.clk(clk), .rst(rst));

    udp_echo_top DUT (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte enables of the last beat from the UDP length (8 header bytes)
    function automatic axis_keep_t last_keep(input udp_len_t len, input logic [7:0] beats);
        int rem;
        rem = int'(len) - 8 - 8 * (int'(beats) - 1);
        return 8'hFF >> (8 - rem);
    endfunction

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (!rst) else begin
            $display("Reset was not released within %0d cycles", TIMEOUT);
            stop_on_error();
        end
    endtask

    // Returns just after the edge that takes the header or beat on offer
    task automatic wait_accept(input bit payload, input string what);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(posedge clk);
            done = payload ? rx_payload_tready : rx_hdr_ready;
            n++;
        end
        assert (done) else begin
            $display("%s was not accepted within %0d cycles", what, TIMEOUT);
            stop_on_error();
        end
        #10;
    endtask

    task automatic drive_row(input row_t row);
        beat_t beat;
        rx_ip_source_ip = row.ip;
        rx_source_port  = row.sport;
        rx_dest_port    = row.dport;
        rx_length       = row.len;
        rx_hdr_valid    = 1'b1;
        if (row.dport == ECHO_PORT) begin
            hdr_q.push_back(row);
        end
        wait_accept(1'b0, "Received header");
        rx_hdr_valid = 1'b0;
        for (int b = 0; b < row.beats; b++) begin
            pay_seed = lcg_next(pay_seed);
            beat.data[63:32] = pay_seed;
            pay_seed = lcg_next(pay_seed);
            beat.data[31:0] = pay_seed;
            beat.last = (b == row.beats - 1);
            beat.keep = beat.last ? last_keep(row.len, row.beats) : 8'hFF;
            beat.user = beat.last && row.user;
            rx_payload_tdata  = beat.data;
            rx_payload_tkeep  = beat.keep;
            rx_payload_tlast  = beat.last;
            rx_payload_tuser  = beat.user;
            rx_payload_tvalid = 1'b1;
            if (row.dport == ECHO_PORT) begin
                beat_q.push_back(beat);
            end
            wait_accept(1'b1, "Payload beat");
        end
        rx_payload_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((hdr_q.size() != 0 || beat_q.size() != 0) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
    endtask

    // Downstream back-pressure, random in the second pass
    always @(posedge clk) begin
        rdy_seed = lcg_next(rdy_seed);
        hold_off = random_ready;
        #10;
        tx_hdr_ready      = !hold_off || rdy_seed[16];
        tx_payload_tready = !hold_off || rdy_seed[24];
    end

    // Reply header: ports swapped, sender IP becomes the destination
    always @(posedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (hdr_q.size() != 0) else begin
                $display("Reply header sent at %0t with no echoed datagram pending", $time);
                stop_on_error();
            end
            hdr_exp = hdr_q.pop_front();
            compare_field("tx_ip_dest_ip", hdr_exp.ip, tx_ip_dest_ip);
            compare_field("tx_source_port", hdr_exp.dport, tx_source_port);
            compare_field("tx_dest_port", hdr_exp.sport, tx_dest_port);
            compare_field("tx_length", hdr_exp.len, tx_length);
        end
    end

    // Payload beats in order, LED follows the first beat of each reply
    always @(posedge clk) begin
        if (rst) begin
            led_exp  = '0;
            tx_first = 1'b1;
        end else begin
            compare_field("led", led_exp, led);
            if (tx_payload_tvalid && tx_payload_tready) begin
                assert (beat_q.size() != 0) else begin
                    $display("Payload beat sent at %0t with no echoed beat pending", $time);
                    stop_on_error();
                end
                beat_exp = beat_q.pop_front();
                compare_field("tx_payload_tdata", beat_exp.data, tx_payload_tdata);
                compare_field("tx_payload_tkeep", beat_exp.keep, tx_payload_tkeep);
                compare_field("tx_payload_tlast", beat_exp.last, tx_payload_tlast);
                compare_field("tx_payload_tuser", beat_exp.user, tx_payload_tuser);
                if (tx_first) begin
                    led_exp = beat_exp.data[7:0];
                end
                tx_first = beat_exp.last;
            end
        end
    end

    initial begin
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        random_ready      = 1'b0;

        repeat (3) @(posedge clk);
        #10;
        compare_field("tx_hdr_valid", 1'b0, tx_hdr_valid);
        compare_field("tx_payload_tvalid", 1'b0, tx_payload_tvalid);
        compare_field("led", '0, led);
        // First cycle after reset is released
        wait_reset_release();
        #10;
        compare_field("tx_hdr_valid", 1'b0, tx_hdr_valid);
        compare_field("tx_payload_tvalid", 1'b0, tx_payload_tvalid);

        for (int pass = 0; pass < 2; pass++) begin
            random_ready = (pass == 1);
            for (int i = 0; i < NUM_ROWS; i++) begin
                drive_row(rows[i]);
            end
        end

        wait_drain();
        // Catch stray output after the last reply
        repeat (20) @(posedge clk);
        if (hdr_q.size() == 0 && beat_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Replies did not arrive within %0d cycles: %0d headers, %0d beats missing",
                     TIMEOUT, hdr_q.size(), beat_q.size());
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// File: files.f
udp_echo_pkg.sv
udp_hdr_if.sv
udp_stream_if.sv
udp_echo_steer.sv
axis_payload_fifo.sv
udp_echo_tx.sv
udp_echo_top.sv
tb_clock_gen.sv
tb_udp_echo.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - files:
      - udp_echo_pkg.sv
      - udp_hdr_if.sv
      - udp_stream_if.sv
      - udp_echo_steer.sv
      - axis_payload_fifo.sv
      - udp_echo_tx.sv
      - udp_echo_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_udp_echo.sv
